/* hw/tetris_pkg.sv */
// Shared field sizes and data types, imported by the puzzle core modules and the testbench
package tetris_pkg;

  // Playing field size in cells
  localparam int ROW_CNT = 20;
  localparam int COL_CNT = 10;

  // Bits per cell, a zero code is an empty cell
  localparam int COLOR_W = 3;

  typedef logic [COLOR_W-1:0] cell_t;

  // Whole field, row 0 on top and column 0 on the left
  typedef cell_t [ROW_CNT-1:0][COL_CNT-1:0] field_t;

  // One flag per row
  typedef logic [ROW_CNT-1:0] row_mask_t;

  // Piece kinds, colour code is kind plus one
  typedef enum logic [2:0] {
    KIND_I, KIND_O, KIND_T, KIND_S, KIND_Z, KIND_J, KIND_L
  } kind_t;

  // User events
  typedef enum logic [2:0] {
    EV_NONE, EV_NEW_GAME, EV_LEFT, EV_RIGHT, EV_DOWN, EV_ROTATE
  } event_t;

  // Moves checked against the field
  typedef enum logic [2:0] {
    MOVE_APPEAR, MOVE_LEFT, MOVE_RIGHT, MOVE_DOWN, MOVE_ROTATE
  } move_t;

  // Signed coordinate of the piece box, may step past a wall while checking
  typedef logic signed [5:0] pos_t;

  // 4x4 shape, index [box row][box column]
  typedef logic [3:0][3:0] mask_t;

  // Box origin of a freshly spawned piece
  localparam pos_t SPAWN_X = pos_t'(3);
  localparam pos_t SPAWN_Y = pos_t'(0);

endpackage

/* hw/piece_if.sv */
// Falling piece bundle, driven by the game controller and read by the move checker and field store
`timescale 1ns/1ps

interface piece_if;

  import tetris_pkg::*;

  // Kind selects the shape and the colour
  kind_t      kind;
  // Box origin in field coordinates
  pos_t       x;
  pos_t       y;
  // Quarter turns clockwise
  logic [1:0] rot;
  // High once the piece has appeared on the field
  logic       draw_en;

  // Controller owns the piece register
  modport ctrl (
    output kind, output x, output y, output rot, output draw_en
  );

  // Checker and field store only look at it
  modport view (
    input kind, input x, input y, input rot, input draw_en
  );

endinterface

/* hw/piece_rom.sv */
// Shape table, instantiated wherever a piece kind and rotation must become a 4x4 cell mask
`timescale 1ns/1ps

module piece_rom
(
  input  tetris_pkg::kind_t kind_i,
  input  logic [1:0]        rot_i,
  output tetris_pkg::mask_t mask_o
);

  import tetris_pkg::*;

  mask_t shape;

  // Clockwise quarter turn about the centre of the upper left 3x3 box
  function automatic mask_t turn_cw(input mask_t m);
    mask_t res;
    res = '0;
    for (int i = 0; i < 3; i++)
      begin
        for (int j = 0; j < 3; j++)
          begin
            // Top row of the old shape becomes the right column
            res[i][j] = m[2-j][i];
          end
      end
    return res;
  endfunction

  always_comb
    begin
      // Rows listed bottom first, bit j of a row is box column j
      case (kind_i)
        KIND_I:  shape = {4'b0000, 4'b0000, 4'b1111, 4'b0000};
        KIND_O:  shape = {4'b0000, 4'b0110, 4'b0110, 4'b0000};
        KIND_T:  shape = {4'b0000, 4'b0000, 4'b0111, 4'b0010};
        KIND_S:  shape = {4'b0000, 4'b0000, 4'b0011, 4'b0110};
        KIND_Z:  shape = {4'b0000, 4'b0000, 4'b0110, 4'b0011};
        KIND_J:  shape = {4'b0000, 4'b0000, 4'b0111, 4'b0001};
        KIND_L:  shape = {4'b0000, 4'b0000, 4'b0111, 4'b0100};
        default: shape = '0;
      endcase

      if (kind_i == KIND_I)
        begin
          // Bar only toggles between flat row 1 and upright column 2
          if (rot_i[0])
            shape = {4'b0100, 4'b0100, 4'b0100, 4'b0100};
        end
      else if (kind_i != KIND_O)
        begin
          // Up to three quarter turns
          for (int r = 0; r < 3; r++)
            if (r < rot_i)
              shape = turn_cw(shape);
        end
    end

  assign mask_o = shape;

endmodule

/* hw/move_checker.sv */
// Move checker, given a move request by the game controller it returns the target and its legality
`timescale 1ns/1ps

module move_checker
#(
  parameter int ROW_CNT = tetris_pkg::ROW_CNT,
  parameter int COL_CNT = tetris_pkg::COL_CNT
)
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               check_run_i,
  input  tetris_pkg::move_t  req_move_i,
  piece_if.view              piece,
  input  tetris_pkg::field_t field_i,
  output logic               check_done_o,
  output logic               can_move_o,
  output tetris_pkg::pos_t   new_x_o,
  output tetris_pkg::pos_t   new_y_o,
  output logic [1:0]         new_rot_o
);

  import tetris_pkg::*;

  pos_t       tgt_x;
  pos_t       tgt_y;
  logic [1:0] tgt_rot;
  mask_t      tgt_mask;
  logic       blocked;

  // Target box origin and rotation for the requested move
  always_comb
    begin
      tgt_x   = piece.x;
      tgt_y   = piece.y;
      tgt_rot = piece.rot;
      case (req_move_i)
        MOVE_APPEAR:
          begin
            // Spawn point, flat orientation
            tgt_x   = SPAWN_X;
            tgt_y   = SPAWN_Y;
            tgt_rot = 2'd0;
          end
        MOVE_LEFT:   tgt_x   = piece.x - pos_t'(1);
        MOVE_RIGHT:  tgt_x   = piece.x + pos_t'(1);
        MOVE_DOWN:   tgt_y   = piece.y + pos_t'(1);
        // Wraps after four turns
        MOVE_ROTATE: tgt_rot = piece.rot + 2'd1;
        default:     tgt_rot = piece.rot;
      endcase
    end

  // Shape at the target rotation
  piece_rom u_piece_rom (
    .kind_i ( piece.kind ),
    .rot_i  ( tgt_rot    ),
    .mask_o ( tgt_mask   )
  );

  // Any set cell off the field or on a settled cell blocks the move
  always_comb
    begin
      int row;
      int col;
      blocked = 1'b0;
      for (int i = 0; i < 4; i++)
        begin
          for (int j = 0; j < 4; j++)
            begin
              row = int'(tgt_y) + i;
              col = int'(tgt_x) + j;
              if (tgt_mask[i][j])
                begin
                  if (col < 0 || col >= COL_CNT || row < 0 || row >= ROW_CNT)
                    blocked = 1'b1;
                  else if (field_i[row][col] != '0)
                    blocked = 1'b1;
                end
            end
        end
    end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        check_done_o <= 1'b0;
        can_move_o   <= 1'b0;
      end
    else
      begin
        // Verdict is ready one cycle after the request
        check_done_o <= check_run_i;
        if (check_run_i)
          can_move_o <= !blocked;
      end

  // Target travels with the verdict
  always_ff @(posedge clk_i)
    if (check_run_i)
      begin
        new_x_o   <= tgt_x;
        new_y_o   <= tgt_y;
        new_rot_o <= tgt_rot;
      end

  // One request at a time, answered on the next cycle
  a_done_after_run: assert property (@(posedge clk_i) disable iff (rst_i)
    check_run_i |=> check_done_o && !check_run_i);

endmodule

/* hw/field_store.sv */
// Settled field storage, written by the game controller's pulses and read as the displayed view
`timescale 1ns/1ps

module field_store
#(
  parameter int ROW_CNT = tetris_pkg::ROW_CNT,
  parameter int COL_CNT = tetris_pkg::COL_CNT
)
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clear_i,
  input  logic               lock_i,
  input  logic               shift_i,
  piece_if.view              piece,
  output tetris_pkg::field_t field_o,
  output tetris_pkg::field_t view_o,
  output logic               any_full_o,
  output logic               top_busy_o
);

  import tetris_pkg::*;

  localparam int ROW_W = $clog2(ROW_CNT);

  field_t            field_q;
  field_t            field_merged;
  field_t            field_shifted;
  row_mask_t         full_rows;
  logic [ROW_W-1:0]  low_row;
  mask_t             piece_mask;
  cell_t             piece_color;

  // Current piece shape
  piece_rom u_piece_rom (
    .kind_i ( piece.kind ),
    .rot_i  ( piece.rot  ),
    .mask_o ( piece_mask )
  );

  assign piece_color = cell_t'(piece.kind) + cell_t'(1);

  // Field with the piece painted in, used for both locking and display
  always_comb
    begin
      int row;
      int col;
      field_merged = field_q;
      for (int i = 0; i < 4; i++)
        begin
          for (int j = 0; j < 4; j++)
            begin
              row = int'(piece.y) + i;
              col = int'(piece.x) + j;
              // Cells outside the field are never painted
              if (piece_mask[i][j] && row >= 0 && row < ROW_CNT && col >= 0 && col < COL_CNT)
                field_merged[row][col] = piece_color;
            end
        end
    end

  // Row is full when no cell in it is empty
  always_comb
    begin
      full_rows = '0;
      for (int r = 0; r < ROW_CNT; r++)
        begin
          full_rows[r] = 1'b1;
          for (int c = 0; c < COL_CNT; c++)
            if (field_q[r][c] == '0)
              full_rows[r] = 1'b0;
        end
    end

  // Lowest full row, the last hit from the top wins
  always_comb
    begin
      low_row = '0;
      for (int r = 0; r < ROW_CNT; r++)
        if (full_rows[r])
          low_row = ROW_W'(r);
    end

  // Rows above the removed one drop by one, top row empties
  always_comb
    begin
      field_shifted = field_q;
      if (any_full_o)
        field_shifted[0] = '0;
      for (int r = 1; r < ROW_CNT; r++)
        if (r <= int'(low_row))
          field_shifted[r] = field_q[r-1];
    end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      field_q <= '0;
    else if (clear_i)
      field_q <= '0;
    else if (lock_i)
      field_q <= field_merged;
    else if (shift_i)
      field_q <= field_shifted;

  assign any_full_o = |full_rows;
  // Settled cell in the spawn row
  assign top_busy_o = |field_q[0];
  assign field_o    = field_q;
  // Piece shown only after it has appeared
  assign view_o     = piece.draw_en ? field_merged : field_q;

  // Controller never locks and clears rows in one cycle
  a_lock_shift_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(lock_i && shift_i));

endmodule

/* hw/game_ctrl.sv */
// Game controller FSM, takes user events and steers the move checker and field store
`timescale 1ns/1ps

module game_ctrl
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  tetris_pkg::event_t  event_i,
  input  logic                event_ready_i,
  output logic                event_rd_o,
  input  tetris_pkg::kind_t   piece_kind_i,
  piece_if.ctrl               piece,
  output logic                check_run_o,
  output tetris_pkg::move_t   req_move_o,
  input  logic                check_done_i,
  input  logic                can_move_i,
  input  tetris_pkg::pos_t    new_x_i,
  input  tetris_pkg::pos_t    new_y_i,
  input  logic [1:0]          new_rot_i,
  input  logic                any_full_i,
  input  logic                top_busy_i,
  output logic                clear_o,
  output logic                lock_o,
  output logic                shift_o,
  output logic                playing_o,
  output logic                game_over_o
);

  import tetris_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE, ST_NEW, ST_GEN, ST_WAIT, ST_CHECK, ST_MAKE, ST_LOCK, ST_LINES, ST_GAME_OVER
  } state_t;

  state_t     state;
  state_t     next_state;
  move_t      ev_move;
  logic       is_move_ev;
  kind_t      kind_q;
  pos_t       x_q;
  pos_t       y_q;
  logic [1:0] rot_q;
  logic       draw_en_q;

  // Events are taken only while idle, waiting or after game over
  assign event_rd_o = event_ready_i &&
                      (state == ST_IDLE || state == ST_WAIT || state == ST_GAME_OVER);

  // Movement events and their moves
  assign is_move_ev = (event_i == EV_LEFT) || (event_i == EV_RIGHT) ||
                      (event_i == EV_DOWN) || (event_i == EV_ROTATE);

  always_comb
    case (event_i)
      EV_LEFT:   ev_move = MOVE_LEFT;
      EV_RIGHT:  ev_move = MOVE_RIGHT;
      EV_ROTATE: ev_move = MOVE_ROTATE;
      default:   ev_move = MOVE_DOWN;
    endcase

  always_comb
    begin
      next_state = state;
      case (state)
        ST_IDLE, ST_GAME_OVER:
          if (event_rd_o && event_i == EV_NEW_GAME)
            next_state = ST_NEW;
        ST_NEW:   next_state = ST_GEN;
        ST_GEN:   next_state = ST_CHECK;
        ST_WAIT:
          if (event_rd_o)
            begin
              // Other codes are consumed and ignored
              if (event_i == EV_NEW_GAME)
                next_state = ST_NEW;
              else if (is_move_ev)
                next_state = ST_CHECK;
            end
        ST_CHECK: next_state = ST_MAKE;
        ST_MAKE:
          if (check_done_i)
            begin
              // Blocked spawn, or blocked fall with the top row taken, ends the game
              if (!can_move_i && req_move_o == MOVE_APPEAR)
                next_state = ST_GAME_OVER;
              else if (!can_move_i && req_move_o == MOVE_DOWN)
                next_state = top_busy_i ? ST_GAME_OVER : ST_LOCK;
              else
                next_state = ST_WAIT;
            end
        ST_LOCK:  next_state = ST_LINES;
        // One full row removed per cycle
        ST_LINES:
          if (!any_full_i)
            next_state = ST_GEN;
        default:  next_state = ST_IDLE;
      endcase
    end

  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      state <= ST_IDLE;
    else
      state <= next_state;

  // Move under test, held through CHECK and MAKE
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      req_move_o <= MOVE_DOWN;
    else if (state == ST_GEN)
      req_move_o <= MOVE_APPEAR;
    else if (state == ST_WAIT && next_state == ST_CHECK)
      req_move_o <= ev_move;

  // Falling piece register
  always_ff @(posedge clk_i or posedge rst_i)
    if (rst_i)
      begin
        kind_q    <= KIND_I;
        x_q       <= '0;
        y_q       <= '0;
        rot_q     <= 2'd0;
        draw_en_q <= 1'b0;
      end
    else
      case (state)
        // Hidden until its spawn has been checked
        ST_NEW, ST_LOCK: draw_en_q <= 1'b0;
        ST_GEN:
          begin
            kind_q    <= piece_kind_i;
            draw_en_q <= 1'b0;
          end
        ST_MAKE:
          if (check_done_i && can_move_i)
            begin
              x_q   <= new_x_i;
              y_q   <= new_y_i;
              rot_q <= new_rot_i;
              if (req_move_o == MOVE_APPEAR)
                draw_en_q <= 1'b1;
            end
        default: draw_en_q <= draw_en_q;
      endcase

  assign piece.kind    = kind_q;
  assign piece.x       = x_q;
  assign piece.y       = y_q;
  assign piece.rot     = rot_q;
  assign piece.draw_en = draw_en_q;

  // Pulses to the checker and field store
  assign check_run_o = (state == ST_CHECK);
  assign clear_o     = (state == ST_NEW);
  assign lock_o      = (state == ST_LOCK);
  assign shift_o     = (state == ST_LINES) && any_full_i;

  assign playing_o   = (state != ST_IDLE) && (state != ST_GAME_OVER);
  assign game_over_o = (state == ST_GAME_OVER);

  // Checker verdict must be there when the move is made, else MAKE would stall
  a_make_has_verdict: assert property (@(posedge clk_i) disable iff (rst_i)
    state == ST_MAKE |-> check_done_i);

endmodule

/* hw/tetris_core.sv */
// Top level of the puzzle core, connects controller, checker and field store to plain ports
`timescale 1ns/1ps

module tetris_core
#(
  parameter int ROW_CNT = tetris_pkg::ROW_CNT,
  parameter int COL_CNT = tetris_pkg::COL_CNT
)
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  tetris_pkg::event_t event_i,
  input  logic               event_ready_i,
  output logic               event_rd_o,
  input  tetris_pkg::kind_t  piece_kind_i,
  output tetris_pkg::field_t field_o,
  output logic               playing_o,
  output logic               game_over_o
);

  import tetris_pkg::*;

  // Controller to checker
  logic       check_run;
  move_t      req_move;
  logic       check_done;
  logic       can_move;
  pos_t       new_x;
  pos_t       new_y;
  logic [1:0] new_rot;
  // Controller to field store
  logic       clear;
  logic       lock;
  logic       shift;
  logic       any_full;
  logic       top_busy;
  // Settled cells only, for collision checks
  field_t     settled;

  piece_if u_piece ();

  game_ctrl u_game_ctrl (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .event_i       ( event_i       ),
    .event_ready_i ( event_ready_i ),
    .event_rd_o    ( event_rd_o    ),
    .piece_kind_i  ( piece_kind_i  ),
    .piece         ( u_piece       ),
    .check_run_o   ( check_run     ),
    .req_move_o    ( req_move      ),
    .check_done_i  ( check_done    ),
    .can_move_i    ( can_move      ),
    .new_x_i       ( new_x         ),
    .new_y_i       ( new_y         ),
    .new_rot_i     ( new_rot       ),
    .any_full_i    ( any_full      ),
    .top_busy_i    ( top_busy      ),
    .clear_o       ( clear         ),
    .lock_o        ( lock          ),
    .shift_o       ( shift         ),
    .playing_o     ( playing_o     ),
    .game_over_o   ( game_over_o   )
  );

  move_checker #(
    .ROW_CNT ( ROW_CNT ),
    .COL_CNT ( COL_CNT )
  ) u_move_checker (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .check_run_i  ( check_run  ),
    .req_move_i   ( req_move   ),
    .piece        ( u_piece    ),
    .field_i      ( settled    ),
    .check_done_o ( check_done ),
    .can_move_o   ( can_move   ),
    .new_x_o      ( new_x      ),
    .new_y_o      ( new_y      ),
    .new_rot_o    ( new_rot    )
  );

  field_store #(
    .ROW_CNT ( ROW_CNT ),
    .COL_CNT ( COL_CNT )
  ) u_field_store (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .clear_i    ( clear    ),
    .lock_i     ( lock     ),
    .shift_i    ( shift    ),
    .piece      ( u_piece  ),
    .field_o    ( settled  ),
    .view_o     ( field_o  ),
    .any_full_o ( any_full ),
    .top_busy_o ( top_busy )
  );

endmodule

/* bench/tb_tetris.sv */
// Testbench for the puzzle core that replays the cases file and checks the shown field and game over
`timescale 1ns/1ps

module tb_tetris;

  import tetris_pkg::*;

  localparam string CASE_FILE   = "bench/tetris_cases.txt";
  // Cycle budget for each line of the cases file
  localparam int    STEP_CYCLES = 400;

  typedef string words_t[$];
  typedef logic [ROW_CNT-1:0][COL_CNT-1:0] occ_t;

  logic   clk_i;
  logic   rst_i;
  event_t event_i;
  logic   event_ready_i;
  logic   event_rd_o;
  kind_t  piece_kind_i;
  field_t field_o;
  logic   playing_o;
  logic   game_over_o;

  string  line_q[$];
  int     step_cnt;
  logic   cases_loaded;
  int     field_errs;
  int     flag_errs;
  int     other_errs;
  // Set once a new game has been requested
  logic   game_started;
  // Outputs captured in the cycle where the core took the last event
  field_t seen_field;
  logic   seen_over;
  logic   seen_play;

  tetris_core #(
    .ROW_CNT ( ROW_CNT ),
    .COL_CNT ( COL_CNT )
  ) u_tetris_core (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .event_i       ( event_i       ),
    .event_ready_i ( event_ready_i ),
    .event_rd_o    ( event_rd_o    ),
    .piece_kind_i  ( piece_kind_i  ),
    .field_o       ( field_o       ),
    .playing_o     ( playing_o     ),
    .game_over_o   ( game_over_o   )
  );

  // 4 ns period
  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Break a text line into words at blanks
  function automatic words_t split_words(input string text);
    words_t words;
    string  cur;
    cur = "";
    for (int i = 0; i < text.len(); i++)
      begin
        if (text[i] == " " || text[i] == "\t" || text[i] == "\n" || text[i] == "\r")
          begin
            if (cur.len() > 0)
              words.push_back(cur);
            cur = "";
          end
        else
          cur = {cur, text.substr(i, i)};
      end
    if (cur.len() > 0)
      words.push_back(cur);
    return words;
  endfunction

  // Occupancy compare per row since colours are not part of the expected data
  task automatic check_field(input string name, input occ_t exp_occ, input field_t act);
    logic [COL_CNT-1:0] act_row;
    for (int r = 0; r < ROW_CNT; r++)
      begin
        for (int c = 0; c < COL_CNT; c++)
          act_row[c] = (act[r][c] != '0);
        if (act_row !== exp_occ[r])
          begin
            field_errs++;
            $display("ERR %s row %0d expected %03h actual %03h", name, r, exp_occ[r], act_row);
          end
      end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
      begin
        flag_errs++;
        $display("ERR %s expected %0b actual %0b", name, exp_val, act_val);
      end
  endtask

  // Offer one event on the falling edge and hold it until the core reads it
  task automatic offer_event(input event_t ev, input kind_t kind);
    @(negedge clk_i);
    event_i       = ev;
    piece_kind_i  = kind;
    event_ready_i = 1'b1;
    // Read strobe sampled halfway to the rising edge
    #1;
    while (!event_rd_o)
      begin
        @(negedge clk_i);
        #1;
      end
    seen_field = field_o;
    seen_over  = game_over_o;
    seen_play  = playing_o;
    @(negedge clk_i);
    event_ready_i = 1'b0;
    event_i       = EV_NONE;
  endtask

  task automatic report_bad_line(input string line);
    other_errs++;
    $display("Malformed line in the cases file: %s", line);
  endtask

  // Event lines replay events and check lines wait until the core takes events again
  task automatic run_line(input string line);
    words_t words;
    occ_t   exp_occ;
    logic   exp_over;
    words = split_words(line);
    case (words[0])
      "E":
        if (words.size() == 4)
          begin
            for (int k = 0; k < words[3].atoi(); k++)
              begin
                offer_event(event_t'(words[1].atoi()), kind_t'(words[2].atoi()));
                if (event_t'(words[1].atoi()) == EV_NEW_GAME)
                  game_started = 1'b1;
                repeat ($urandom_range(3)) @(negedge clk_i);
              end
          end
        else
          report_bad_line(line);
      "F":
        if (words.size() == ROW_CNT + 2)
          begin
            for (int r = 0; r < ROW_CNT; r++)
              exp_occ[r] = COL_CNT'(words[r + 2].atohex());
            // EV_NONE is read and dropped once the core is idle
            offer_event(EV_NONE, piece_kind_i);
            check_field(words[1], exp_occ, seen_field);
          end
        else
          report_bad_line(line);
      "O":
        if (words.size() == 3)
          begin
            exp_over = logic'(words[2].atoi());
            offer_event(EV_NONE, piece_kind_i);
            check_flag(words[1], exp_over, seen_over);
            // Playing from the first new game until the game is over
            check_flag({words[1], "_playing"}, game_started && !exp_over, seen_play);
          end
        else
          report_bad_line(line);
      default: report_bad_line(line);
    endcase
  endtask

  initial
    begin
      int     fd;
      string  line;
      string  tag;
      words_t words;
      rst_i         = 1'b1;
      event_i       = EV_NONE;
      event_ready_i = 1'b0;
      piece_kind_i  = KIND_I;
      field_errs    = 0;
      flag_errs     = 0;
      other_errs    = 0;
      step_cnt      = 0;
      cases_loaded  = 1'b0;
      game_started  = 1'b0;
      void'($urandom(30383));

      // Keep case lines and count them for the watchdog
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0)
        begin
          other_errs++;
          $display("Could not open the cases file %s", CASE_FILE);
        end
      else
        begin
          while ($fgets(line, fd) != 0)
            begin
              words = split_words(line);
              if (words.size() > 0)
                begin
                  tag = words[0];
                  if (tag.substr(0, 0) != "#")
                    begin
                      line_q.push_back(line);
                      step_cnt++;
                    end
                end
            end
          $fclose(fd);
        end
      cases_loaded = 1'b1;

      repeat (16) @(negedge clk_i);
      rst_i = 1'b0;

      foreach (line_q[n])
        run_line(line_q[n]);

      $display("Errors: field %0d flag %0d other %0d", field_errs, flag_errs, other_errs);
      if (field_errs + flag_errs + other_errs == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end

  // Watchdog sized from the number of case lines
  initial
    begin
      wait (cases_loaded);
      repeat (STEP_CYCLES * step_cnt + 80) @(posedge clk_i);
      $display("Timeout: the core stopped reading events within %0d case lines", step_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end

endmodule

/* bench/tetris_cases.txt */
# E <event> <kind> <repeat>: event 1 new game 2 left 3 right 4 down 5 rotate, kind 0 I 1 O
# F <name> <row 0 ... row 19>: occupancy mask per row in hex, bit c is column c
# O <name> <game_over>: expected game over flag
F after_reset 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
O after_reset 0
E 1 1 1
F spawn_o 000 030 030 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
E 1 0 1
E 2 0 5
F left_wall 000 00f 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
E 1 0 1
E 5 0 1
F rotate_i1 020 020 020 020 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
E 5 0 3
F rotate_i4 000 078 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
E 1 1 1
E 4 1 17
F o_floor 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 030 030
E 4 1 1
F o_locked 000 030 030 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 030 030
E 1 0 1
E 2 0 3
E 4 0 19
E 3 0 1
E 4 1 19
E 3 1 4
E 4 1 17
F row_full 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 300 3ff
E 4 1 1
F row_clear 000 030 030 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 300
E 1 1 1
E 4 1 90
O game_over 1
F stack 000 000 030 030 030 030 030 030 030 030 030 030 030 030 030 030 030 030 030 030
E 1 1 1
O restart 0
F restart 000 030 030 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000

/* filelist.f */
hw/tetris_pkg.sv
hw/piece_if.sv
hw/piece_rom.sv
hw/move_checker.sv
hw/field_store.sv
hw/game_ctrl.sv
hw/tetris_core.sv
bench/tb_tetris.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_tetris
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
